/* tb/periph_input.txt */
# op addr data expect resp  (op W write, R read, X set ext_irq_i, I wait irq_o == data)
# addr, data, expect and resp in hex; resp 0 is OKAY, 2 is SLVERR
I 000 00000000 00000000 0
R 000 00000000 00000000 0
R 008 00000000 00000000 0
R 104 00000000 00000000 0
R 100 00000000 00000000 0
W 008 12345678 00000000 0
R 008 00000000 12345678 0
W 004 00000abc 00000000 0
R 004 00000000 00000abc 0
W 104 000000a5 00000000 0
R 104 00000000 000000a5 0
W 200 11111111 00000000 2
R 200 00000000 deadbeef 2
W 004 00000000 00000000 0
W 008 00000014 00000000 0
W 104 00000001 00000000 0
W 000 00000001 00000000 0
I 000 00000001 00000000 0
W 000 00000000 00000000 0
R 100 00000000 00000001 0
W 100 00000001 00000000 0
R 100 00000000 00000000 0
I 000 00000000 00000000 0
W 104 00000028 00000000 0
X 000 00000014 00000000 0
I 000 00000001 00000000 0
R 108 00000000 00000004 0
R 108 00000000 00000006 0
R 108 00000000 00000000 0
I 000 00000000 00000000 0

/* tb.f */
+incdir+verilog
verilog/axil_pkg.sv
verilog/periph_pkg.sv
verilog/axil_reg_fsm.sv
verilog/cmp_timer.sv
verilog/irq_ctrl.sv
verilog/periph_subsys.sv
tb/tb_periph_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f \
    --top-module tb_periph_subsys \
    -Mdir obj_dir

./obj_dir/Vtb_periph_subsys

/* tb/tb_periph_subsys.sv */
/*
 * Testbench for the peripheral subsystem
 * Replays AXI4-Lite operations from the input data file
 * Random response back-pressure, checks data, responses and irq_o
 */
`timescale 1ns/1ps
`include "periph_cfg.svh"

module tb_periph_subsys;
    localparam int TIMEOUT = 100;

    logic                       clk;
    logic                       rst_n;
    axil_pkg::axil_req_t        req;
    axil_pkg::axil_rsp_t        rsp;
    logic [`PERIPH_NUM_SRC-2:0] ext_irq;
    logic                       irq;

    periph_subsys periph_subsys_i (
        .clk_i      ( clk     ),
        .rst_n_i    ( rst_n   ),
        .axil_req_i ( req     ),
        .axil_rsp_o ( rsp     ),
        .ext_irq_i  ( ext_irq ),
        .irq_o      ( irq     )
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR: %s got 0x%08h expected 0x%08h", name, actual, expected));
        end
    endtask

    // Ready is combinational, so look just after the falling edge drive
    task automatic wait_addr_ready(input logic is_write);
        int cycles;
        cycles = 0;
        #1;
        while (!(is_write ? (rsp.aw_ready && rsp.w_ready) : rsp.ar_ready)) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout: the DUT never accepted the address");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic wait_resp_valid(input logic is_write);
        int cycles;
        cycles = 0;
        while (!(is_write ? rsp.b_valid : rsp.r_valid)) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout: the DUT never returned a response");
            @(negedge clk);
        end
    endtask

    task automatic wait_irq_level(input logic level);
        int cycles;
        cycles = 0;
        while (irq !== level) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout: irq_o never reached the expected level");
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        logic [1:0]  first_resp;
        int unsigned delay;
        req.aw_valid = 1'b1;
        req.aw_addr  = addr;
        req.w_valid  = 1'b1;
        req.w_data   = data;
        req.w_strb   = 4'hf;
        wait_addr_ready(1'b1);
        @(negedge clk);
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
        wait_resp_valid(1'b1);
        first_resp = rsp.b_resp;
        delay = $urandom % 4;
        repeat (delay) begin
            @(negedge clk);
            check_val("b_valid", 32'(rsp.b_valid), 32'd1);
            check_val("b_resp", 32'(rsp.b_resp), 32'(first_resp));
        end
        req.b_ready = 1'b1;
        check_val("b_resp", 32'(rsp.b_resp), 32'(exp_resp));
        @(negedge clk);
        req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
        logic [31:0] first_data;
        logic [1:0]  first_resp;
        int unsigned delay;
        req.ar_valid = 1'b1;
        req.ar_addr  = addr;
        wait_addr_ready(1'b0);
        @(negedge clk);
        req.ar_valid = 1'b0;
        wait_resp_valid(1'b0);
        first_data = rsp.r_data;
        first_resp = rsp.r_resp;
        delay = $urandom % 4;
        repeat (delay) begin
            @(negedge clk);
            check_val("r_valid", 32'(rsp.r_valid), 32'd1);
            check_val("r_data", rsp.r_data, first_data);
            check_val("r_resp", 32'(rsp.r_resp), 32'(first_resp));
        end
        req.r_ready = 1'b1;
        check_val("r_data", rsp.r_data, exp_data);
        check_val("r_resp", 32'(rsp.r_resp), 32'(exp_resp));
        @(negedge clk);
        req.r_ready = 1'b0;
    endtask

    // ----------------------------------------
    initial begin
        int          fd;
        int          count;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr, data, exp_val, resp;
        clk     = 1'b0;
        rst_n   = 1'b0;
        req     = '0;
        ext_irq = '0;
        void'($urandom(44));
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        fd = $fopen("tb/periph_input.txt", "r");
        if (fd == 0) abort_run("Could not open tb/periph_input.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            count = $sscanf(line, "%c %h %h %h %h", op, addr, data, exp_val, resp);
            if (count != 5) abort_run($sformatf("Malformed stimulus line: %s", line));
            case (op)
                "W": axil_write(addr[11:0], data, resp[1:0]);
                "R": axil_read(addr[11:0], exp_val, resp[1:0]);
                "X": ext_irq = data[`PERIPH_NUM_SRC-2:0];
                "I": wait_irq_level(data[0]);
                default: abort_run($sformatf("Unknown operation in line: %s", line));
            endcase
        end
        $fclose(fd);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* verilog/periph_subsys.sv */
/*
 * Peripheral subsystem top
 * AXI4-Lite register FSM, compare timer, interrupt controller
 */
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_subsys (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  axil_pkg::axil_req_t        axil_req_i,
    output axil_pkg::axil_rsp_t        axil_rsp_o,
    input  logic [`PERIPH_NUM_SRC-2:0] ext_irq_i,
    output logic                       irq_o
);
    periph_pkg::reg_req_t timer_req, irq_req;
    periph_pkg::reg_rsp_t timer_rsp, irq_rsp;
    logic                 timer_evt;

    // ----------------------------------------
    axil_reg_fsm axil_reg_fsm_i (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .axil_req_i  ( axil_req_i ),
        .axil_rsp_o  ( axil_rsp_o ),
        .timer_req_o ( timer_req  ),
        .irq_req_o   ( irq_req    ),
        .timer_rsp_i ( timer_rsp  ),
        .irq_rsp_i   ( irq_rsp    )
    );

    cmp_timer cmp_timer_i (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .reg_req_i   ( timer_req  ),
        .reg_rsp_o   ( timer_rsp  ),
        .timer_evt_o ( timer_evt  )
    );

    // Timer event feeds source 0
    irq_ctrl irq_ctrl_i (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .reg_req_i   ( irq_req    ),
        .reg_rsp_o   ( irq_rsp    ),
        .timer_evt_i ( timer_evt  ),
        .ext_irq_i   ( ext_irq_i  ),
        .irq_o       ( irq_o      )
    );

endmodule

/* verilog/irq_ctrl.sv */
/*
 * Interrupt controller
 * Rising-edge capture into pending bits, enable mask
 * Lowest-ID-first claim and a registered interrupt output
 */
`timescale 1ns/1ps
`include "periph_cfg.svh"

module irq_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  periph_pkg::reg_req_t       reg_req_i,
    output periph_pkg::reg_rsp_t       reg_rsp_o,
    input  logic                       timer_evt_i,
    input  logic [`PERIPH_NUM_SRC-2:0] ext_irq_i,
    output logic                       irq_o
);
    localparam int DW  = `PERIPH_DATA_W;
    localparam int NS  = `PERIPH_NUM_SRC;
    localparam int IDW = $clog2(NS) + 1;

    periph_pkg::irq_vec_t src, src_q, rise;
    periph_pkg::irq_vec_t pending_q, enable_q;
    periph_pkg::irq_vec_t active, claim_hot, clr_mask;
    logic                 irq_q;
    logic [IDW-1:0]       claim_id;
    logic                 wr_en, rd_en;

    assign wr_en = reg_req_i.valid && reg_req_i.write;
    assign rd_en = reg_req_i.valid && !reg_req_i.write;

    // Source 0 is the timer
    assign src       = {ext_irq_i, timer_evt_i};
    assign rise      = src & ~src_q;
    assign active    = pending_q & enable_q;
    assign claim_hot = active & (~active + 1'b1); // lowest set bit

    always_comb begin
        claim_id = '0;
        for (int i = NS - 1; i >= 0; i--) begin
            if (active[i]) claim_id = IDW'(i + 1);
        end
    end

    // ----------------------------------------
    // Pending clears from W1C and claim
    always_comb begin
        clr_mask = '0;
        if (wr_en && reg_req_i.offset == `PERIPH_IRQ_PENDING && reg_req_i.wstrb[0]) begin
            clr_mask = reg_req_i.wdata[NS-1:0];
        end
        if (rd_en && reg_req_i.offset == `PERIPH_IRQ_CLAIM) begin
            clr_mask = clr_mask | claim_hot;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_q     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
            irq_q     <= 1'b0;
        end else begin
            src_q     <= src;
            pending_q <= (pending_q & ~clr_mask) | rise; // new edge wins
            if (wr_en && reg_req_i.offset == `PERIPH_IRQ_ENABLE && reg_req_i.wstrb[0]) begin
                enable_q <= reg_req_i.wdata[NS-1:0];
            end
            irq_q <= |active;
        end
    end

    assign irq_o = irq_q;

    always_comb begin
        case (reg_req_i.offset)
            `PERIPH_IRQ_PENDING: reg_rsp_o.rdata = DW'(pending_q);
            `PERIPH_IRQ_ENABLE:  reg_rsp_o.rdata = DW'(enable_q);
            `PERIPH_IRQ_CLAIM:   reg_rsp_o.rdata = DW'(claim_id);
            default:             reg_rsp_o.rdata = '0;
        endcase
    end

    a_masked_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        enable_q == '0 |=> !irq_o);

endmodule

/* verilog/cmp_timer.sv */
/*
 * Compare timer
 * Enable, count and compare registers
 * One-cycle event when count hits compare, then wraps to 0
 */
`timescale 1ns/1ps
`include "periph_cfg.svh"

module cmp_timer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::reg_req_t reg_req_i,
    output periph_pkg::reg_rsp_t reg_rsp_o,
    output logic                 timer_evt_o
);
    localparam int DW = `PERIPH_DATA_W;

    logic          enable_q;
    logic [DW-1:0] count_q;
    logic [DW-1:0] cmp_q;
    logic          wr_en;

    assign wr_en       = reg_req_i.valid && reg_req_i.write;
    assign timer_evt_o = enable_q && (count_q == cmp_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            count_q  <= '0;
            cmp_q    <= '0;
        end else begin
            if (wr_en && reg_req_i.offset == `PERIPH_TIMER_CTRL && reg_req_i.wstrb[0]) begin
                enable_q <= reg_req_i.wdata[0];
            end
            if (wr_en && reg_req_i.offset == `PERIPH_TIMER_CMP) begin
                cmp_q <= periph_pkg::apply_strb(cmp_q, reg_req_i.wdata, reg_req_i.wstrb);
            end
            // Software load beats counting
            if (wr_en && reg_req_i.offset == `PERIPH_TIMER_COUNT) begin
                count_q <= periph_pkg::apply_strb(count_q, reg_req_i.wdata, reg_req_i.wstrb);
            end else if (timer_evt_o) begin
                count_q <= '0;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        case (reg_req_i.offset)
            `PERIPH_TIMER_CTRL:  reg_rsp_o.rdata = DW'(enable_q);
            `PERIPH_TIMER_COUNT: reg_rsp_o.rdata = count_q;
            `PERIPH_TIMER_CMP:   reg_rsp_o.rdata = cmp_q;
            default:             reg_rsp_o.rdata = '0;
        endcase
    end

    // A disabled timer left alone stays frozen and silent
    a_idle_silent: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !enable_q && !wr_en |=> !timer_evt_o && $stable(count_q));

endmodule

/* verilog/axil_reg_fsm.sv */
/*
 * AXI4-Lite slave for the peripheral register space
 * One access at a time through IDLE, ACCESS and RESP
 * Decodes timer and interrupt regions and answers SLVERR elsewhere
 */
`timescale 1ns/1ps
`include "periph_cfg.svh"

module axil_reg_fsm (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  axil_pkg::axil_req_t  axil_req_i,
    output axil_pkg::axil_rsp_t  axil_rsp_o,
    output periph_pkg::reg_req_t timer_req_o,
    output periph_pkg::reg_req_t irq_req_o,
    input  periph_pkg::reg_rsp_t timer_rsp_i,
    input  periph_pkg::reg_rsp_t irq_rsp_i
);
    localparam int AW = `PERIPH_ADDR_W;
    localparam int DW = `PERIPH_DATA_W;
    localparam logic [AW-1:0] TIMER_BASE = `PERIPH_TIMER_BASE;
    localparam logic [AW-1:0] IRQ_BASE   = `PERIPH_IRQ_BASE;

    typedef enum logic [1:0] {IDLE, ACCESS, RESP} state_e;

    state_e               state_q, state_d;
    logic                 is_write_q;
    logic                 timer_hit_q, irq_hit_q;
    logic [3:0]           addr_q;
    logic [DW-1:0]        wdata_q;
    logic [DW/8-1:0]      wstrb_q;
    logic [DW-1:0]        rdata_q;
    axil_pkg::axil_resp_e resp_q;

    logic                 wr_go, rd_go, accept, resp_done;
    logic [AW-1:0]        addr_in;

    // ----------------------------------------
    // Writes win a tie with reads
    assign wr_go  = (state_q == IDLE) && axil_req_i.aw_valid && axil_req_i.w_valid;
    assign rd_go  = (state_q == IDLE) && axil_req_i.ar_valid &&
                    !axil_req_i.aw_valid && !axil_req_i.w_valid;
    assign accept = wr_go || rd_go;
    assign addr_in = wr_go ? axil_req_i.aw_addr : axil_req_i.ar_addr;

    assign resp_done = (state_q == RESP) &&
                       (is_write_q ? axil_req_i.b_ready : axil_req_i.r_ready);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = ACCESS;
            ACCESS:  state_d = RESP;
            RESP:    if (resp_done) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            is_write_q  <= 1'b0;
            timer_hit_q <= 1'b0;
            irq_hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                is_write_q  <= wr_go;
                timer_hit_q <= addr_in[AW-1:4] == TIMER_BASE[AW-1:4];
                irq_hit_q   <= addr_in[AW-1:4] == IRQ_BASE[AW-1:4];
            end
        end
    end

    // Payload captured on accept and at end of strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_q  <= '0;
            wdata_q <= '0;
            wstrb_q <= '0;
            rdata_q <= '0;
            resp_q  <= axil_pkg::OKAY;
        end else begin
            if (accept) begin
                addr_q  <= addr_in[3:0];
                wdata_q <= axil_req_i.w_data;
                wstrb_q <= axil_req_i.w_strb;
            end
            if (state_q == ACCESS) begin
                if (timer_hit_q) begin
                    rdata_q <= timer_rsp_i.rdata;
                    resp_q  <= axil_pkg::OKAY;
                end else if (irq_hit_q) begin
                    rdata_q <= irq_rsp_i.rdata;
                    resp_q  <= axil_pkg::OKAY;
                end else begin
                    rdata_q <= `PERIPH_BAD_DATA; // no target behind this address
                    resp_q  <= axil_pkg::SLVERR;
                end
            end
        end
    end

    // ----------------------------------------
    // Target strobes share one payload
    always_comb begin
        timer_req_o.valid  = (state_q == ACCESS) && timer_hit_q;
        timer_req_o.write  = is_write_q;
        timer_req_o.offset = addr_q;
        timer_req_o.wdata  = wdata_q;
        timer_req_o.wstrb  = wstrb_q;
        irq_req_o          = timer_req_o;
        irq_req_o.valid    = (state_q == ACCESS) && irq_hit_q;
    end

    assign axil_rsp_o.aw_ready = wr_go;
    assign axil_rsp_o.w_ready  = wr_go;
    assign axil_rsp_o.ar_ready = rd_go;
    assign axil_rsp_o.b_valid  = (state_q == RESP) && is_write_q;
    assign axil_rsp_o.b_resp   = resp_q;
    assign axil_rsp_o.r_valid  = (state_q == RESP) && !is_write_q;
    assign axil_rsp_o.r_data   = rdata_q;
    assign axil_rsp_o.r_resp   = resp_q;

    // ----------------------------------------
    a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_o.b_valid && !axil_req_i.b_ready |=>
            axil_rsp_o.b_valid && $stable(axil_rsp_o.b_resp));

    a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_o.r_valid && !axil_req_i.r_ready |=>
            axil_rsp_o.r_valid && $stable(axil_rsp_o.r_data));

    a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(timer_req_o.valid && irq_req_o.valid));

endmodule

/* verilog/periph_pkg.sv */
/*
 * Internal register bus and interrupt types
 * Request and response structs, source vector, byte strobe merge
 */
`include "periph_cfg.svh"

package periph_pkg;

    // One register access, valid for a single cycle
    typedef struct packed {
        logic                          valid;
        logic                          write;
        logic [3:0]                    offset;
        logic [`PERIPH_DATA_W-1:0]     wdata;
        logic [`PERIPH_DATA_W/8-1:0]   wstrb;
    } reg_req_t;

    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0]     rdata;
    } reg_rsp_t;

    typedef logic [`PERIPH_NUM_SRC-1:0] irq_vec_t;

    // Merge write data into a register under byte strobes
    function automatic logic [`PERIPH_DATA_W-1:0] apply_strb(
        input logic [`PERIPH_DATA_W-1:0]   old_val,
        input logic [`PERIPH_DATA_W-1:0]   new_val,
        input logic [`PERIPH_DATA_W/8-1:0] strb
    );
        logic [`PERIPH_DATA_W-1:0] res;
        res = old_val;
        for (int b = 0; b < `PERIPH_DATA_W/8; b++) begin
            if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
    endfunction

endpackage

/* verilog/axil_pkg.sv */
/*
 * AXI4-Lite channel types
 * Response code enum, master and slave side structs
 */
`include "periph_cfg.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Driven by the master
    typedef struct packed {
        logic                          aw_valid;
        logic [`PERIPH_ADDR_W-1:0]     aw_addr;
        logic                          w_valid;
        logic [`PERIPH_DATA_W-1:0]     w_data;
        logic [`PERIPH_DATA_W/8-1:0]   w_strb;
        logic                          b_ready;
        logic                          ar_valid;
        logic [`PERIPH_ADDR_W-1:0]     ar_addr;
        logic                          r_ready;
    } axil_req_t;

    // Driven by the slave
    typedef struct packed {
        logic                          aw_ready;
        logic                          w_ready;
        logic                          b_valid;
        axil_resp_e                    b_resp;
        logic                          ar_ready;
        logic                          r_valid;
        logic [`PERIPH_DATA_W-1:0]     r_data;
        axil_resp_e                    r_resp;
    } axil_rsp_t;

endpackage

/* verilog/periph_cfg.svh */
/*
 * Configuration macros for the peripheral subsystem
 * Bus widths, region bases, register offsets, source count
 */
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Bus widths
`define PERIPH_ADDR_W      12
`define PERIPH_DATA_W      32

// Source 0 is the timer, 1..7 are external lines
`define PERIPH_NUM_SRC     8

// Region bases, 16 bytes each
`define PERIPH_TIMER_BASE  12'h000
`define PERIPH_IRQ_BASE    12'h100

// ----------------------------------------
// Register offsets within a region
`define PERIPH_TIMER_CTRL  4'h0 // bit 0 enable
`define PERIPH_TIMER_COUNT 4'h4
`define PERIPH_TIMER_CMP   4'h8
`define PERIPH_IRQ_PENDING 4'h0 // write 1 to clear
`define PERIPH_IRQ_ENABLE  4'h4
`define PERIPH_IRQ_CLAIM   4'h8 // read only

`define PERIPH_BAD_DATA    32'hDEAD_BEEF

`endif
